// ==== Makefile ====
# Verilator build and run of the host link testbench

TOP := tb_hps_link

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+verif
source/hps_link_pkg.sv
source/cmd_framer.sv
source/user_io_regs.sv
source/file_download.sv
source/hps_link_top.sv
verif/tb_hps_link.sv

// ==== source/cmd_framer.sv ====
// tracks host frames: first strobe is the command, the rest are data words
// outputs one-cycle strobes one clock after the host strobe

`default_nettype none

module cmd_framer (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  hps_link_pkg::host_req_t  host,
	output hps_link_pkg::frame_t     frame
);

	import hps_link_pkg::*;

	// set once the command word of the current frame has been taken
	logic has_cmd;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			has_cmd <= 1'b0;
			frame   <= '0;
		end else begin
			frame.cmd_strobe  <= 1'b0;
			frame.data_strobe <= 1'b0;

			if (!host.enable) begin
				// idle between frames, cmd parks at zero
				has_cmd        <= 1'b0;
				frame.cmd      <= '0;
				frame.word_idx <= '0;
			end else if (host.strobe) begin
				frame.data <= host.din;
				if (!has_cmd) begin
					has_cmd          <= 1'b1;
					frame.cmd        <= host.din;
					frame.word_idx   <= '0;
					frame.cmd_strobe <= 1'b1;
				end else begin
					if (frame.word_idx != '1) begin
						frame.word_idx <= frame.word_idx + word_idx_w'(1);
					end
					frame.data_strobe <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// a word is either the command or data, never both
	strobe_onehot: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(frame.cmd_strobe && frame.data_strobe)
	);

	// long frames stick at the top count instead of wrapping
	word_idx_saturates: assert property (
		@(posedge clk_sys) disable iff (reset)
		(host.enable && frame.word_idx == '1) |=> (frame.word_idx == '1)
	);

endmodule

`default_nettype wire

// ==== source/file_download.sv ====
// file download engine: drives the ioctl write bus from framed commands
// 16-bit data words, the address steps by 2 per word

`default_nettype none

module file_download (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  hps_link_pkg::frame_t   frame,
	output hps_link_pkg::ioctl_t   ioctl
);

	import hps_link_pkg::*;

	logic                 info_hit;
	logic                 index_hit;
	logic                 tx_hit;
	logic                 dat_hit;
	logic                 tx_start;
	logic                 dl_active;
	logic                 wr_req;
	logic                 dl_wr;
	logic [dl_addr_w-1:0] addr_next;
	logic [dl_addr_w-1:0] dl_addr;
	logic [7:0]           dl_index;
	word_t                dl_dout;
	logic [31:0]          dl_ext;

	assign info_hit  = frame.data_strobe && (frame.cmd == cmd_file_info);
	assign index_hit = frame.data_strobe && (frame.cmd == cmd_file_index);
	assign tx_hit    = frame.data_strobe && (frame.cmd == cmd_file_tx);
	assign dat_hit   = frame.data_strobe && (frame.cmd == cmd_file_dat);
	assign tx_start  = (frame.data[7:0] != 8'h00);

	////////////////////////////////////////////////////////////
	// download state and write strobe
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_active <= 1'b0;
			wr_req    <= 1'b0;
			dl_wr     <= 1'b0;
			addr_next <= '0;
		end else begin
			// wr trails the published address and data by one clock
			dl_wr  <= wr_req;
			wr_req <= dat_hit;

			if (tx_hit) begin
				dl_active <= tx_start;
				if (tx_start) addr_next <= '0;
			end
			if (dat_hit) begin
				addr_next <= addr_next + dl_addr_w'(2);
			end
		end
	end

	// payload registers
	always_ff @(posedge clk_sys) begin
		if (info_hit && frame.word_idx == word_idx_w'(1)) dl_ext[31:16] <= frame.data;
		if (info_hit && frame.word_idx == word_idx_w'(2)) dl_ext[15:0] <= frame.data;
		if (index_hit) dl_index <= frame.data[7:0];
		// on stop the final address is left on the bus
		if ((tx_hit && !tx_start) || dat_hit) dl_addr <= addr_next;
		if (dat_hit) dl_dout <= frame.data;
	end

	assign ioctl = '{
		download: dl_active,
		index:    dl_index,
		wr:       dl_wr,
		addr:     dl_addr,
		dout:     dl_dout,
		file_ext: dl_ext
	};

	// host paces words at most every other cycle, so writes never merge
	wr_single: assert property (
		@(posedge clk_sys) disable iff (reset)
		ioctl.wr |=> !ioctl.wr
	);

endmodule

`default_nettype wire

// ==== source/hps_link_pkg.sv ====
// shared types and constants for the host link
// import into the module body, use scoped names in port lists

`default_nettype none

package hps_link_pkg;

	////////////////////////////////////////////////////////////
	// host word and frame tracking
	////////////////////////////////////////////////////////////

	localparam int word_w = 16;
	typedef logic [word_w-1:0] word_t;

	// data-word counter, saturates at all ones
	localparam int word_idx_w = 10;

	typedef struct packed {
		logic  enable;
		logic  strobe;
		word_t din;
	} host_req_t;

	// cmd and word_idx hold between strobes, data is the last strobed word
	typedef struct packed {
		word_t                 cmd;
		word_t                 data;
		logic [word_idx_w-1:0] word_idx;
		logic                  cmd_strobe;
		logic                  data_strobe;
	} frame_t;

	////////////////////////////////////////////////////////////
	// command codes
	////////////////////////////////////////////////////////////

	localparam word_t cmd_cfg        = 16'h0001;
	localparam word_t cmd_joy0       = 16'h0002;
	localparam word_t cmd_joy1       = 16'h0003;
	localparam word_t cmd_kbd_get    = 16'h0004;
	localparam word_t cmd_kbd_put    = 16'h0005;
	localparam word_t cmd_joy_raw    = 16'h000F;
	localparam word_t cmd_joy2       = 16'h0010;
	localparam word_t cmd_joy3       = 16'h0011;
	localparam word_t cmd_status     = 16'h001E;
	localparam word_t cmd_status_req = 16'h0029;
	localparam word_t cmd_menumask   = 16'h002E;
	localparam word_t cmd_file_tx    = 16'h0053;
	localparam word_t cmd_file_dat   = 16'h0054;
	localparam word_t cmd_file_index = 16'h0055;
	localparam word_t cmd_file_info  = 16'h0056;

	////////////////////////////////////////////////////////////
	// user inputs
	////////////////////////////////////////////////////////////

	localparam int num_joy = 4;
	typedef logic [31:0] joy_t;

	// from cfg bits 1:0 and 4
	typedef struct packed {
		logic [1:0] buttons;
		logic       forced_scandoubler;
	} user_cfg_t;

	localparam logic [3:0] kbd_tag    = 4'hA;
	localparam logic [3:0] status_tag = 4'hA;

	////////////////////////////////////////////////////////////
	// file download bus
	////////////////////////////////////////////////////////////

	localparam int dl_addr_w = 27;

	typedef struct packed {
		logic                 download;
		logic [7:0]           index;
		logic                 wr;
		logic [dl_addr_w-1:0] addr;
		word_t                dout;
		logic [31:0]          file_ext;
	} ioctl_t;

endpackage

`default_nettype wire

// ==== source/hps_link_top.sv ====
// top of the host link: framer feeding the register block and download engine
// the reply word comes from the register block only

`default_nettype none

module hps_link_top (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  hps_link_pkg::host_req_t   host,
	input  hps_link_pkg::word_t       joy_raw,
	input  hps_link_pkg::word_t       status_menumask,
	input  wire [63:0]                status_in,
	input  wire                       status_set,
	input  wire [7:0]                 kbd_out_data,
	input  wire                       kbd_out_strobe,
	output hps_link_pkg::word_t       io_dout,
	output hps_link_pkg::user_cfg_t   user_cfg,
	output hps_link_pkg::joy_t        joystick [hps_link_pkg::num_joy],
	output logic [63:0]               status,
	output logic [7:0]                kbd_in_data,
	output logic                      kbd_in_strobe,
	output hps_link_pkg::ioctl_t      ioctl
);

	import hps_link_pkg::*;

	frame_t frame;
	word_t  regs_dout;

	cmd_framer u_framer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.host    (host),
		.frame   (frame)
	);

	user_io_regs u_regs (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.frame           (frame),
		.joy_raw         (joy_raw),
		.status_menumask (status_menumask),
		.status_in       (status_in),
		.status_set      (status_set),
		.kbd_out_data    (kbd_out_data),
		.kbd_out_strobe  (kbd_out_strobe),
		.user_cfg        (user_cfg),
		.joystick        (joystick),
		.status          (status),
		.kbd_in_data     (kbd_in_data),
		.kbd_in_strobe   (kbd_in_strobe),
		.io_dout         (regs_dout)
	);

	// download commands never answer
	file_download u_download (
		.clk_sys (clk_sys),
		.reset   (reset),
		.frame   (frame),
		.ioctl   (ioctl)
	);

	assign io_dout = regs_dout;

endmodule

`default_nettype wire

// ==== source/user_io_regs.sv ====
// user-input registers: config, joysticks, status and keyboard mailbox
// decodes framed commands and answers with a registered reply word

`default_nettype none

module user_io_regs (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  hps_link_pkg::frame_t      frame,
	input  hps_link_pkg::word_t       joy_raw,
	input  hps_link_pkg::word_t       status_menumask,
	input  wire [63:0]                status_in,
	input  wire                       status_set,
	input  wire [7:0]                 kbd_out_data,
	input  wire                       kbd_out_strobe,
	output hps_link_pkg::user_cfg_t   user_cfg,
	output hps_link_pkg::joy_t        joystick [hps_link_pkg::num_joy],
	output logic [63:0]               status,
	output logic [7:0]                kbd_in_data,
	output logic                      kbd_in_strobe,
	output hps_link_pkg::word_t       io_dout
);

	import hps_link_pkg::*;

	logic                       first_word;
	logic                       quarter_hit;
	logic [1:0]                 quarter;
	logic                       joy_hit;
	logic [$clog2(num_joy)-1:0] joy_sel;
	logic                       status_set_q;
	logic [3:0]                 status_cnt;
	logic [63:0]                status_req;
	logic                       kbd_strobe_q;
	logic                       kbd_pending;
	word_t                      reply;

	assign first_word = (frame.word_idx == word_idx_w'(1));

	// words 1..4 map onto the four 16-bit quarters of a 64-bit word
	assign quarter_hit = (frame.word_idx != '0) && (frame.word_idx <= word_idx_w'(4));
	assign quarter     = frame.word_idx[1:0] - 2'd1;

	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 2'd0;
		case (frame.cmd)
			cmd_joy0: joy_sel = 2'd0;
			cmd_joy1: joy_sel = 2'd1;
			cmd_joy2: joy_sel = 2'd2;
			cmd_joy3: joy_sel = 2'd3;
			default:  joy_hit = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// register writes and edge detection
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			user_cfg      <= '0;
			joystick      <= '{default: '0};
			status        <= '0;
			status_set_q  <= 1'b0;
			status_cnt    <= '0;
			kbd_strobe_q  <= 1'b0;
			kbd_pending   <= 1'b0;
			kbd_in_strobe <= 1'b0;
		end else begin
			status_set_q  <= status_set;
			kbd_strobe_q  <= kbd_out_strobe;
			kbd_in_strobe <= 1'b0;

			if (status_set && !status_set_q) begin
				status_cnt <= status_cnt + 4'd1;
			end
			if (kbd_out_strobe && !kbd_strobe_q) begin
				kbd_pending <= 1'b1;
			end

			if (frame.data_strobe) begin
				if (frame.cmd == cmd_cfg && first_word) begin
					user_cfg.buttons            <= frame.data[1:0];
					user_cfg.forced_scandoubler <= frame.data[4];
				end
				if (joy_hit) begin
					if (first_word) joystick[joy_sel][15:0] <= frame.data;
					else joystick[joy_sel][31:16] <= frame.data;
				end
				if (frame.cmd == cmd_status && quarter_hit) begin
					status[{quarter, 4'b0000} +: 16] <= frame.data;
				end
				// reading the mailbox status acknowledges it
				if (frame.cmd == cmd_kbd_get && first_word) begin
					kbd_pending <= 1'b0;
				end
				if (frame.cmd == cmd_kbd_put && first_word) begin
					kbd_in_strobe <= 1'b1;
				end
			end
		end
	end

	// snapshot of status_in taken at the core's request
	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_q) begin
			status_req <= status_in;
		end
		if (frame.data_strobe && frame.cmd == cmd_kbd_put && first_word) begin
			kbd_in_data <= frame.data[7:0];
		end
	end

	////////////////////////////////////////////////////////////
	// reply word
	////////////////////////////////////////////////////////////

	always_comb begin
		reply = '0;
		if (frame.cmd_strobe) begin
			if (frame.cmd == cmd_status_req) reply = {8'h00, status_tag, status_cnt};
		end else begin
			case (frame.cmd)
				cmd_kbd_get: begin
					if (first_word) reply = {8'h00, kbd_tag, 3'b000, kbd_pending};
					else reply = {8'h00, kbd_out_data};
				end
				cmd_joy_raw:    reply = joy_raw;
				cmd_menumask:   if (first_word) reply = status_menumask;
				cmd_status_req: if (quarter_hit) reply = status_req[{quarter, 4'b0000} +: 16];
				default:        reply = '0;
			endcase
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (frame.cmd_strobe || frame.data_strobe) begin
			io_dout <= reply;
		end else if (frame.cmd == '0) begin
			// no frame open
			io_dout <= '0;
		end
	end

	// the core sees one pulse per put command
	kbd_in_single: assert property (
		@(posedge clk_sys) disable iff (reset)
		kbd_in_strobe |=> !kbd_in_strobe
	);

endmodule

`default_nettype wire

// ==== verif/hps_link_tasks.svh ====
// host-side frame tasks and the reference model of the host link
// included in the testbench module body, after the signal declarations

`ifndef hps_link_tasks_svh
`define hps_link_tasks_svh

function automatic word_t rand_word();
	return word_t'($random(seed));
endfunction

function automatic logic [1:0] joy_slot(input word_t cmd);
	case (cmd)
		cmd_joy1: return 2'd1;
		cmd_joy2: return 2'd2;
		cmd_joy3: return 2'd3;
		default:  return 2'd0;
	endcase
endfunction

// expected reply to word idx of a frame, the command word being idx 0
function automatic word_t expect_reply(input word_t cmd, input int idx);
	logic [1:0] q;
	q = 2'(idx - 1);
	if (idx == 0) begin
		return (cmd == cmd_status_req) ? {8'h00, status_tag, m_cnt} : word_t'(0);
	end
	case (cmd)
		cmd_kbd_get: begin
			if (idx == 1) return {8'h00, kbd_tag, 3'b000, m_pending};
			return {8'h00, kbd_out_data};
		end
		cmd_joy_raw:    return joy_raw;
		cmd_menumask:   return (idx == 1) ? status_menumask : word_t'(0);
		cmd_status_req: return (idx <= 4) ? m_req[{q, 4'b0000} +: 16] : word_t'(0);
		default:        return '0;
	endcase
endfunction

// register side effects of one data word
function automatic void apply_write(input word_t cmd, input int idx, input word_t data);
	logic [1:0] q;
	q = 2'(idx - 1);
	if (idx == 0) return;
	case (cmd)
		cmd_cfg: begin
			if (idx == 1) begin
				m_cfg.buttons            = data[1:0];
				m_cfg.forced_scandoubler = data[4];
			end
		end
		cmd_joy0, cmd_joy1, cmd_joy2, cmd_joy3: begin
			if (idx == 1)
				m_joy[joy_slot(cmd)][15:0] = data;
			else
				m_joy[joy_slot(cmd)][31:16] = data;
		end
		cmd_status:  if (idx <= 4) m_status[{q, 4'b0000} +: 16] = data;
		cmd_kbd_get: if (idx == 1) m_pending = 1'b0;
		cmd_kbd_put: if (idx == 1) m_kbd_in = data[7:0];
		default: ;
	endcase
endfunction

task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
	name_q.push_back(name);
	exp_q.push_back(exp);
	act_q.push_back(act);
endtask

task automatic check_regs(input string name);
	check_value({name, ": user_cfg"}, 64'(m_cfg), 64'(user_cfg));
	for (int j = 0; j < num_joy; j++) begin
		check_value($sformatf("%s: joystick %0d", name, j), 64'(m_joy[j]), 64'(joystick[j]));
	end
	check_value({name, ": status"}, m_status, status);
endtask

// one frame of the words in tx_q, each reply sampled two cycles after its strobe
task automatic send_frame(input string name);
	word_t exp;
	@(negedge clk_sys);
	host.enable = 1'b1;
	for (int i = 0; i < tx_q.size(); i++) begin
		@(negedge clk_sys);
		host.strobe = 1'b1;
		host.din    = tx_q[i];
		exp         = expect_reply(tx_q[0], i);
		apply_write(tx_q[0], i, tx_q[i]);
		@(negedge clk_sys);
		host.strobe = 1'b0;
		@(negedge clk_sys);
		check_value($sformatf("%s word %0d", name, i), 64'(exp), 64'(io_dout));
	end
	@(negedge clk_sys);
	host.enable = 1'b0;
	repeat (2) @(negedge clk_sys);
	check_value({name, ": idle reply"}, 64'(0), 64'(io_dout));
	check_regs(name);
	tx_q.delete();
endtask

task automatic send_random(input string name, input word_t cmd, input int n);
	tx_q.push_back(cmd);
	repeat (n) tx_q.push_back(rand_word());
	send_frame(name);
endtask

`endif

// ==== verif/tb_hps_link.sv ====
// testbench for the host link top
// sends host frames and checks replies, user-input registers,
// the keyboard mailbox and the download bus

`default_nettype none

module tb_hps_link;

	import hps_link_pkg::*;

	localparam int clk_period  = 20;
	localparam int dl_words    = 24;
	localparam int total_words = 54 + dl_words;
	// 4 clocks per word plus margin for frame gaps, reset and core pulses
	localparam int watchdog_cycles = total_words * 4 + 200;

	logic        clk_sys;
	logic        reset;
	host_req_t   host;
	word_t       joy_raw;
	word_t       status_menumask;
	logic [63:0] status_in;
	logic        status_set;
	logic [7:0]  kbd_out_data;
	logic        kbd_out_strobe;
	word_t       io_dout;
	user_cfg_t   user_cfg;
	joy_t        joystick [num_joy];
	logic [63:0] status;
	logic [7:0]  kbd_in_data;
	logic        kbd_in_strobe;
	ioctl_t      ioctl;

	// reference model state
	user_cfg_t   m_cfg;
	joy_t        m_joy [num_joy];
	logic [63:0] m_status;
	logic [63:0] m_req;
	logic [3:0]  m_cnt;
	logic        m_pending;
	logic [7:0]  m_kbd_in;

	integer               seed = 32'h040c70a1;
	word_t                tx_q[$];
	string                name_q[$];
	logic [63:0]          exp_q[$];
	logic [63:0]          act_q[$];
	int                   kbd_pulses;
	logic [7:0]           kbd_byte;
	logic [dl_addr_w-1:0] wr_addr_q[$];
	word_t                wr_data_q[$];
	word_t                dl_sent[$];
	word_t                info_hi;
	word_t                info_lo;
	word_t                idx_word;
	word_t                tmp;

	`include "hps_link_tasks.svh"

	hps_link_top DUT (.*);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	task automatic pulse_status_set(input logic [63:0] value);
		@(negedge clk_sys);
		status_in  = value;
		status_set = 1'b1;
		m_req      = value;
		m_cnt      = m_cnt + 4'd1;
		@(negedge clk_sys);
		status_set = 1'b0;
	endtask

	task automatic pulse_kbd_out(input logic [7:0] value);
		@(negedge clk_sys);
		kbd_out_data   = value;
		kbd_out_strobe = 1'b1;
		m_pending      = 1'b1;
		@(negedge clk_sys);
		kbd_out_strobe = 1'b0;
	endtask

	// core-side monitor sampled between clock edges
	always @(negedge clk_sys) begin
		if (kbd_in_strobe) begin
			kbd_pulses = kbd_pulses + 1;
			kbd_byte   = kbd_in_data;
		end
		if (ioctl.wr) begin
			wr_addr_q.push_back(ioctl.addr);
			wr_data_q.push_back(ioctl.dout);
			check_value("download during write", 64'(1), 64'(ioctl.download));
		end
	end

	always @(negedge clk_sys) begin : compare_proc
		string       c_name;
		logic [63:0] c_exp;
		logic [63:0] c_act;
		while (act_q.size() != 0) begin
			c_name = name_q.pop_front();
			c_exp  = exp_q.pop_front();
			c_act  = act_q.pop_front();
			assert (c_act == c_exp) else begin
				$display("Fail %s: expected %h, actual %h", c_name, c_exp, c_act);
				$display("ERRORS FOUND");
				$fatal(1, "stopped at the first mismatch");
			end
		end
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog: run did not finish within %0d clock cycles", watchdog_cycles);
	end

	initial begin
		clk_sys         = 1'b0;
		reset           = 1'b1;
		host            = '0;
		joy_raw         = '0;
		status_menumask = '0;
		status_in       = '0;
		status_set      = 1'b0;
		kbd_out_data    = '0;
		kbd_out_strobe  = 1'b0;
		m_cfg           = '0;
		m_joy           = '{default: '0};
		m_status        = '0;
		m_req           = '0;
		m_cnt           = '0;
		m_pending       = 1'b0;
		m_kbd_in        = '0;
		kbd_pulses      = 0;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;

		// control outputs idle after reset
		check_regs("after reset");
		check_value("download after reset", 64'(0), 64'(ioctl.download));
		check_value("wr after reset", 64'(0), 64'(ioctl.wr));
		check_value("kbd_in_strobe after reset", 64'(0), 64'(kbd_in_strobe));

		send_random("cfg write", cmd_cfg, 1);
		send_random("joystick 0", cmd_joy0, 2);
		send_random("joystick 1", cmd_joy1, 2);
		send_random("joystick 2", cmd_joy2, 2);
		send_random("joystick 3", cmd_joy3, 2);

		send_random("status write", cmd_status, 4);
		pulse_status_set({rand_word(), rand_word(), rand_word(), rand_word()});
		send_random("status request 1", cmd_status_req, 4);
		pulse_status_set({rand_word(), rand_word(), rand_word(), rand_word()});
		send_random("status request 2", cmd_status_req, 4);

		// mailbox flag set and read, then read again once clear
		tmp = rand_word();
		pulse_kbd_out(tmp[7:0]);
		send_random("kbd get", cmd_kbd_get, 2);
		send_random("kbd get again", cmd_kbd_get, 1);
		kbd_pulses = 0;
		send_random("kbd put", cmd_kbd_put, 1);
		check_value("kbd_in_strobe pulses", 64'(1), 64'(kbd_pulses));
		check_value("kbd_in_data", 64'(m_kbd_in), 64'(kbd_byte));

		joy_raw         = rand_word();
		status_menumask = rand_word();
		send_random("raw joystick", cmd_joy_raw, 2);
		send_random("menu mask", cmd_menumask, 2);
		send_random("unknown command", 16'h0077, 1);

		////////////////////////////////////////////////////////////
		// file download
		////////////////////////////////////////////////////////////
		info_hi  = rand_word();
		info_lo  = rand_word();
		idx_word = rand_word();
		tx_q.push_back(cmd_file_info);
		tx_q.push_back(info_hi);
		tx_q.push_back(info_lo);
		send_frame("file info");
		tx_q.push_back(cmd_file_index);
		tx_q.push_back(idx_word);
		send_frame("file index");
		check_value("download before start", 64'(0), 64'(ioctl.download));

		tx_q.push_back(cmd_file_tx);
		tx_q.push_back(rand_word() | 16'h0001);
		send_frame("download start");
		check_value("download after start", 64'(1), 64'(ioctl.download));

		tx_q.push_back(cmd_file_dat);
		for (int i = 0; i < dl_words; i++) begin
			tmp = rand_word();
			dl_sent.push_back(tmp);
			tx_q.push_back(tmp);
		end
		send_frame("download data");

		tx_q.push_back(cmd_file_tx);
		tx_q.push_back(rand_word() & 16'hff00);
		send_frame("download stop");
		check_value("download after stop", 64'(0), 64'(ioctl.download));
		check_value("write count", 64'(dl_words), 64'(wr_addr_q.size()));
		for (int i = 0; i < wr_addr_q.size(); i++) begin
			check_value($sformatf("write %0d addr", i), 64'(2 * i), 64'(wr_addr_q[i]));
			check_value($sformatf("write %0d data", i), 64'(dl_sent[i]), 64'(wr_data_q[i]));
		end
		check_value("final address", 64'(2 * dl_words), 64'(ioctl.addr));
		check_value("file_ext", 64'({info_hi, info_lo}), 64'(ioctl.file_ext));
		check_value("index", 64'(idx_word[7:0]), 64'(ioctl.index));

		repeat (3) @(negedge clk_sys);
		if (act_q.size() == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("ERRORS FOUND");
			$fatal(1, "checks were left unprocessed");
		end
	end

endmodule

`default_nettype wire
